// ==== lq_dir_defs.svh ====
`ifndef LQ_DIR_DEFS_SVH
`define LQ_DIR_DEFS_SVH

// Directory geometry
`define LQ_DIR_WAYS       8
`define LQ_DIR_TAG_W      12
`define LQ_DIR_CCLASS_W   4

// One parity bit covers a group of tag bits, the last group padded with zeros
`define LQ_DIR_PAR_GRP    8
`define LQ_DIR_PAR_W      ((`LQ_DIR_TAG_W + `LQ_DIR_PAR_GRP - 1) / `LQ_DIR_PAR_GRP)

// Config register selects
`define LQ_DIR_CFG_DCDIS  2'd0
`define LQ_DIR_CFG_INJ_LD 2'd1
`define LQ_DIR_CFG_INJ_ST 2'd2

`endif

// ==== lq_dir_pkg.sv ====
`default_nettype none

`include "lq_dir_defs.svh"

package lq_dir_pkg;

   typedef logic [`LQ_DIR_TAG_W-1:0] lq_dir_tag_t;
   typedef logic [`LQ_DIR_PAR_W-1:0] lq_dir_par_t;
   // Way a sits at bit 0
   typedef logic [`LQ_DIR_WAYS-1:0]  lq_dir_way_vec_t;

   typedef struct packed {
      logic [`LQ_DIR_CCLASS_W-1:0] cclass;
      lq_dir_tag_t                 tag;
   } lq_dir_addr_t;

   typedef struct packed {
      logic         valid;
      lq_dir_addr_t addr;
   } lq_dir_ld_req_t;

   typedef struct packed {
      logic            valid;
      lq_dir_addr_t    addr;
      lq_dir_way_vec_t way_upd;
   } lq_dir_st_req_t;

   typedef struct packed {
      lq_dir_way_vec_t             way;
      logic [`LQ_DIR_CCLASS_W-1:0] cclass;
      lq_dir_tag_t                 tag;
   } lq_dir_wr_t;

   // Raw parity errors here are not yet qualified by any lookup
   typedef struct packed {
      lq_dir_tag_t [`LQ_DIR_WAYS-1:0] tag;
      lq_dir_par_t [`LQ_DIR_WAYS-1:0] par;
      lq_dir_way_vec_t                perr;
   } lq_dir_rd_t;

   typedef struct packed {
      logic            valid;
      lq_dir_way_vec_t cmp;
      lq_dir_way_vec_t perr;
   } lq_dir_port_rsp_t;

   typedef struct packed {
      logic dcdis;
      logic inj_ld;
      logic inj_st;
   } lq_dir_cfg_t;

   typedef struct packed {
      logic       req;
      logic [1:0] sel;
      logic       data;
   } lq_dir_cfg_wr_t;

endpackage

`default_nettype wire

// ==== lq_dir_cfg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lq_dir_defs.svh"

module lq_dir_cfg (
   input  wire logic                       nclk,
   input  wire logic                       rst_n,
   input  wire lq_dir_pkg::lq_dir_cfg_wr_t cfg_wr,
   output logic                            cfg_ack,
   output lq_dir_pkg::lq_dir_cfg_t         cfg
);
   import lq_dir_pkg::*;

   lq_dir_cfg_t cfg_nxt;
   logic        wr_start;

   // The selected bit is written once, while req is up and ack has not answered yet
   assign wr_start = cfg_wr.req & ~cfg_ack;

   always_comb begin
      cfg_nxt = cfg;
      if (wr_start) begin
         case (cfg_wr.sel)
            `LQ_DIR_CFG_DCDIS: cfg_nxt.dcdis = cfg_wr.data;
            `LQ_DIR_CFG_INJ_LD: cfg_nxt.inj_ld = cfg_wr.data;
            `LQ_DIR_CFG_INJ_ST: cfg_nxt.inj_st = cfg_wr.data;
            default: cfg_nxt = cfg;
         endcase
      end
   end

   // Ack follows req one edge later in both directions
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         cfg     <= '0;
         cfg_ack <= 1'b0;
      end else begin
         cfg     <= cfg_nxt;
         cfg_ack <= cfg_wr.req;
      end
   end

endmodule

`default_nettype wire

// ==== lq_dir_tag_arr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lq_dir_defs.svh"

module lq_dir_tag_arr (
   input  wire logic                        nclk,
   input  wire logic                        rst_n,
   input  wire lq_dir_pkg::lq_dir_wr_t      wr,
   input  wire logic [`LQ_DIR_CCLASS_W-1:0] rd0_cclass,
   input  wire logic [`LQ_DIR_CCLASS_W-1:0] rd1_cclass,
   input  wire logic                        inj_p0,
   input  wire logic                        inj_p1,
   output lq_dir_pkg::lq_dir_rd_t           rd0,
   output lq_dir_pkg::lq_dir_rd_t           rd1
);
   import lq_dir_pkg::*;

   localparam int SETS  = 1 << `LQ_DIR_CCLASS_W;
   localparam int PORTS = 2;

   lq_dir_tag_t                 tag_mem [SETS][`LQ_DIR_WAYS];
   lq_dir_par_t                 par_mem [SETS][`LQ_DIR_WAYS];
   lq_dir_par_t                 wr_par;

   logic [`LQ_DIR_CCLASS_W-1:0] rd_cclass [PORTS];
   logic                        rd_inj [PORTS];
   lq_dir_tag_t                 rd_tag_q [PORTS][`LQ_DIR_WAYS];
   lq_dir_par_t                 rd_par_q [PORTS][`LQ_DIR_WAYS];
   lq_dir_rd_t                  rd_out [PORTS];

   // XOR of each group of tag bits
   function automatic lq_dir_par_t par_gen(input lq_dir_tag_t tag);
      logic [`LQ_DIR_PAR_W*`LQ_DIR_PAR_GRP-1:0] padded;
      lq_dir_par_t                              par;
      padded = '0;
      padded[`LQ_DIR_TAG_W-1:0] = tag;
      for (int g = 0; g < `LQ_DIR_PAR_W; g++) begin
         par[g] = ^padded[g*`LQ_DIR_PAR_GRP +: `LQ_DIR_PAR_GRP];
      end
      return par;
   endfunction

   assign wr_par = par_gen(wr.tag);

   assign rd_cclass[0] = rd0_cclass;
   assign rd_cclass[1] = rd1_cclass;
   assign rd_inj[0]    = inj_p0;
   assign rd_inj[1]    = inj_p1;

   // Tag 0 has parity 0, so a cleared entry is consistent
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
               tag_mem[s][w] <= '0;
               par_mem[s][w] <= '0;
            end
         end
      end else begin
         for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
            if (wr.way[w]) begin
               tag_mem[wr.cclass][w] <= wr.tag;
               par_mem[wr.cclass][w] <= wr_par;
            end
         end
      end
   end

   // Read data is captured on the edge, so a write on the same edge is not seen
   always_ff @(posedge nclk) begin
      for (int p = 0; p < PORTS; p++) begin
         for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
            rd_tag_q[p][w] <= tag_mem[rd_cclass[p]][w];
            rd_par_q[p][w] <= par_mem[rd_cclass[p]][w];
         end
      end
   end

   always_comb begin
      lq_dir_par_t par_eff;
      for (int p = 0; p < PORTS; p++) begin
         for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
            // Injection flips parity bit 0 on every way of the port
            par_eff = rd_par_q[p][w] ^ lq_dir_par_t'(rd_inj[p]);
            rd_out[p].tag[w]  = rd_tag_q[p][w];
            rd_out[p].par[w]  = par_eff;
            rd_out[p].perr[w] = (par_eff != par_gen(rd_tag_q[p][w]));
         end
      end
   end

   assign rd0 = rd_out[0];
   assign rd1 = rd_out[1];

endmodule

`default_nettype wire

// ==== lq_dir_port_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lq_dir_defs.svh"

module lq_dir_port_chk (
   input  wire logic                    nclk,
   input  wire logic                    rst_n,
   input  wire logic                    lookup_val,
   input  wire lq_dir_pkg::lq_dir_tag_t lookup_tag,
   input  wire lq_dir_pkg::lq_dir_rd_t  rd,
   input  wire logic                    dcdis,
   output lq_dir_pkg::lq_dir_port_rsp_t rsp
);
   import lq_dir_pkg::*;

   logic        val_q;
   logic        chk_en_q;
   lq_dir_tag_t tag_q;

   // Staged alongside the array read so both land in the same cycle
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         val_q    <= 1'b0;
         chk_en_q <= 1'b0;
      end else begin
         val_q    <= lookup_val;
         chk_en_q <= lookup_val & ~dcdis;
      end
   end

   always_ff @(posedge nclk) begin
      tag_q <= lookup_tag;
   end

   always_comb begin
      rsp.valid = val_q;
      for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
         rsp.cmp[w] = (rd.tag[w] == tag_q);
      end
      // Errors count only for a real lookup with the cache enabled
      rsp.perr = rd.perr & {`LQ_DIR_WAYS{chk_en_q}};
   end

endmodule

`default_nettype wire

// ==== lq_dir_stq_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lq_dir_defs.svh"

module lq_dir_stq_pipe (
   input  wire logic                       nclk,
   input  wire logic                       rst_n,
   input  wire lq_dir_pkg::lq_dir_st_req_t st_req,
   output logic [`LQ_DIR_CCLASS_W-1:0]     stq2_cclass,
   output lq_dir_pkg::lq_dir_st_req_t      stq2,
   output lq_dir_pkg::lq_dir_wr_t          wr
);
   import lq_dir_pkg::*;

   lq_dir_st_req_t stq3;

   // Advances every cycle, only the valid bits are cleared by reset
   always_ff @(posedge nclk) begin
      stq2 <= st_req;
      stq3 <= stq2;
      if (!rst_n) begin
         stq2.valid <= 1'b0;
         stq3.valid <= 1'b0;
      end
   end

   assign stq2_cclass = stq2.addr.cclass;

   // The array takes this write on the edge that moves the store into stq4,
   // which is the edge after its stq3 compare was read
   always_comb begin
      wr.way    = stq3.valid ? stq3.way_upd : '0;
      wr.cclass = stq3.addr.cclass;
      wr.tag    = stq3.addr.tag;
   end

endmodule

`default_nettype wire

// ==== lq_dir_tag.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lq_dir_defs.svh"

module lq_dir_tag (
   input  wire logic                       nclk,
   input  wire logic                       rst_n,
   input  wire lq_dir_pkg::lq_dir_cfg_wr_t cfg_wr,
   output logic                            cfg_ack,
   input  wire lq_dir_pkg::lq_dir_ld_req_t ld_req,
   output lq_dir_pkg::lq_dir_port_rsp_t    ld_rsp,
   output lq_dir_pkg::lq_dir_rd_t          ld_rd,
   input  wire lq_dir_pkg::lq_dir_st_req_t st_req,
   output lq_dir_pkg::lq_dir_port_rsp_t    st_rsp
);
   import lq_dir_pkg::*;

   lq_dir_cfg_t                 cfg;
   lq_dir_wr_t                  wr;
   lq_dir_st_req_t              stq2;
   logic [`LQ_DIR_CCLASS_W-1:0] stq2_cclass;
   lq_dir_rd_t                  st_rd;

   lq_dir_cfg cfg0 (
      .nclk    (nclk),
      .rst_n   (rst_n),
      .cfg_wr  (cfg_wr),
      .cfg_ack (cfg_ack),
      .cfg     (cfg)
   );

   // Port 0 serves loads, port 1 serves the store pipe at stq2
   lq_dir_tag_arr arr0 (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .wr         (wr),
      .rd0_cclass (ld_req.addr.cclass),
      .rd1_cclass (stq2_cclass),
      .inj_p0     (cfg.inj_ld),
      .inj_p1     (cfg.inj_st),
      .rd0        (ld_rd),
      .rd1        (st_rd)
   );

   lq_dir_stq_pipe stq_pipe0 (
      .nclk        (nclk),
      .rst_n       (rst_n),
      .st_req      (st_req),
      .stq2_cclass (stq2_cclass),
      .stq2        (stq2),
      .wr          (wr)
   );

   lq_dir_port_chk ld_chk (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .lookup_val (ld_req.valid),
      .lookup_tag (ld_req.addr.tag),
      .rd         (ld_rd),
      .dcdis      (cfg.dcdis),
      .rsp        (ld_rsp)
   );

   lq_dir_port_chk st_chk (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .lookup_val (stq2.valid),
      .lookup_tag (stq2.addr.tag),
      .rd         (st_rd),
      .dcdis      (cfg.dcdis),
      .rsp        (st_rsp)
   );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
   output logic nclk,
   output logic rst_n
);
   initial begin
      nclk = 1'b0;
      forever #50 nclk = ~nclk;
   end

   // Reset is held for the first 10 rising edges
   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge nclk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== tb_lq_dir_tag.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lq_dir_defs.svh"

module tb_lq_dir_tag;
   import lq_dir_pkg::*;

   typedef logic [`LQ_DIR_CCLASS_W-1:0] cclass_t;
   localparam int TIMEOUT = 20;

   logic             nclk;
   logic             rst_n;
   lq_dir_cfg_wr_t   cfg_wr;
   logic             cfg_ack;
   lq_dir_ld_req_t   ld_req;
   lq_dir_port_rsp_t ld_rsp;
   lq_dir_rd_t       ld_rd;
   lq_dir_st_req_t   st_req;
   lq_dir_port_rsp_t st_rsp;

   logic [31:0]      lfsr = 32'h3884;
   lq_dir_tag_t      model [1 << `LQ_DIR_CCLASS_W][`LQ_DIR_WAYS];
   int               errs = 0;
   int               tests = 0;

   tb_clkgen clk0 (
      .nclk  (nclk),
      .rst_n (rst_n)
   );

   lq_dir_tag dut0 (
      .nclk    (nclk),
      .rst_n   (rst_n),
      .cfg_wr  (cfg_wr),
      .cfg_ack (cfg_ack),
      .ld_req  (ld_req),
      .ld_rsp  (ld_rsp),
      .ld_rd   (ld_rd),
      .st_req  (st_req),
      .st_rsp  (st_rsp)
   );

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   // Each tag bit folds into the parity bit of its 8-bit group
   function automatic lq_dir_par_t exp_par(input lq_dir_tag_t tag);
      lq_dir_par_t p;
      p = '0;
      for (int b = 0; b < `LQ_DIR_TAG_W; b++) begin
         p[b / `LQ_DIR_PAR_GRP] = p[b / `LQ_DIR_PAR_GRP] ^ tag[b];
      end
      return p;
   endfunction

   function automatic lq_dir_way_vec_t model_cmp(input cclass_t cls, input lq_dir_tag_t tag);
      lq_dir_way_vec_t v;
      for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
         v[w] = (model[cls][w] == tag);
      end
      return v;
   endfunction

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      errs++;
   endtask

   task automatic end_test(input string name, input int e0);
      tests++;
      $display("test %s: %0d errors", name, errs - e0);
   endtask

   task automatic do_load(input cclass_t cls, input lq_dir_tag_t tag, input logic inj,
                          input lq_dir_way_vec_t exp_perr);
      lq_dir_ld_req_t  req;
      lq_dir_par_t     p;
      lq_dir_way_vec_t raw_perr;
      int              cnt;
      logic            got;
      req.valid = 1'b1;
      req.addr.cclass = cls;
      req.addr.tag = tag;
      // Stored parity is always correct, so only an injection makes it disagree
      raw_perr = {`LQ_DIR_WAYS{inj}};
      @(posedge nclk);
      ld_req <= req;
      cnt = 0;
      got = 1'b0;
      while (!got && cnt < TIMEOUT) begin
         @(posedge nclk);
         ld_req <= '0;
         cnt++;
         @(negedge nclk);
         got = ld_rsp.valid;
      end
      if (!got) begin
         $display("Load response did not arrive within %0d cycles", TIMEOUT);
         errs++;
      end else begin
         if (cnt != 1) begin
            $display("Load response came after %0d cycles instead of 1", cnt);
            errs++;
         end
         if (ld_rsp.cmp !== model_cmp(cls, tag))
            mismatch("ld_rsp.cmp", 32'(model_cmp(cls, tag)), 32'(ld_rsp.cmp));
         if (ld_rsp.perr !== exp_perr)
            mismatch("ld_rsp.perr", 32'(exp_perr), 32'(ld_rsp.perr));
         if (ld_rd.perr !== raw_perr)
            mismatch("ld_rd.perr", 32'(raw_perr), 32'(ld_rd.perr));
         for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
            p = exp_par(model[cls][w]);
            p[0] = p[0] ^ inj;
            if (ld_rd.tag[w] !== model[cls][w])
               mismatch($sformatf("ld_rd.tag[%0d]", w), 32'(model[cls][w]), 32'(ld_rd.tag[w]));
            if (ld_rd.par[w] !== p)
               mismatch($sformatf("ld_rd.par[%0d]", w), 32'(p), 32'(ld_rd.par[w]));
         end
      end
   endtask

   // Store i is driven at edge i, compared at edge i+2 and written at edge i+3,
   // so its compare sees every store up to i-2 but not i-1
   task automatic run_stores(input int n, input logic few_tags, input lq_dir_way_vec_t exp_perr);
      lq_dir_st_req_t  seq [16];
      lq_dir_st_req_t  s;
      lq_dir_way_vec_t exp_cmp;
      for (int k = 0; k < n; k++) begin
         seq[k].valid = 1'b1;
         seq[k].addr.cclass = few_tags ? cclass_t'(rand_bits(1)) : cclass_t'(rand_bits(4));
         seq[k].addr.tag = few_tags ? lq_dir_tag_t'({rand_bits(2), 10'h2a5})
                                    : lq_dir_tag_t'(rand_bits(12));
         seq[k].way_upd = lq_dir_way_vec_t'(rand_bits(8));
      end
      for (int c = 0; c < n + 3; c++) begin
         @(posedge nclk);
         st_req <= (c < n) ? seq[c] : '0;
         @(negedge nclk);
         if (c >= 2 && c - 2 < n) begin
            s = seq[c-2];
            exp_cmp = model_cmp(s.addr.cclass, s.addr.tag);
            if (st_rsp.valid !== 1'b1) begin
               $display("Store response missing two cycles after store %0d entered", c - 2);
               errs++;
            end
            if (st_rsp.cmp !== exp_cmp)
               mismatch("st_rsp.cmp", 32'(exp_cmp), 32'(st_rsp.cmp));
            if (st_rsp.perr !== exp_perr)
               mismatch("st_rsp.perr", 32'(exp_perr), 32'(st_rsp.perr));
         end else if (st_rsp.valid !== 1'b0) begin
            mismatch("st_rsp.valid", 0, 32'(st_rsp.valid));
         end
         if (c >= 3) begin
            s = seq[c-3];
            for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
               if (s.way_upd[w])
                  model[s.addr.cclass][w] = s.addr.tag;
            end
         end
      end
   endtask

   task automatic cfg_write(input logic [1:0] sel, input logic data);
      lq_dir_cfg_wr_t req;
      int             cnt;
      req.req = 1'b1;
      req.sel = sel;
      req.data = data;
      if (cfg_ack !== 1'b0) begin
         $display("Config ack was high before a new request");
         errs++;
      end
      @(posedge nclk);
      cfg_wr <= req;
      cnt = 0;
      do begin
         @(negedge nclk);
         cnt++;
      end while (cfg_ack !== 1'b1 && cnt < TIMEOUT);
      if (cfg_ack !== 1'b1) begin
         $display("Config ack did not rise within %0d cycles", TIMEOUT);
         errs++;
      end else if (cnt < 2) begin
         $display("Config ack rose before req was sampled");
         errs++;
      end
      @(posedge nclk);
      cfg_wr.req <= 1'b0;
      cnt = 0;
      do begin
         @(negedge nclk);
         cnt++;
      end while (cfg_ack !== 1'b0 && cnt < TIMEOUT);
      if (cfg_ack !== 1'b0) begin
         $display("Config ack did not fall within %0d cycles", TIMEOUT);
         errs++;
      end
   endtask

   task automatic test_reset_state();
      int      e0;
      cclass_t cls;
      e0 = errs;
      @(negedge nclk);
      if (ld_rsp.valid !== 1'b0)
         mismatch("ld_rsp.valid", 0, 32'(ld_rsp.valid));
      if (st_rsp.valid !== 1'b0)
         mismatch("st_rsp.valid", 0, 32'(st_rsp.valid));
      if (cfg_ack !== 1'b0)
         mismatch("cfg_ack", 0, 32'(cfg_ack));
      for (int k = 0; k < 4; k++) begin
         cls = cclass_t'(rand_bits(4));
         do_load(cls, '0, 1'b0, '0);
         do_load(cls, lq_dir_tag_t'({rand_bits(11), 1'b1}), 1'b0, '0);
      end
      end_test("reset_state", e0);
   endtask

   task automatic test_store_load();
      int      e0;
      cclass_t cls;
      e0 = errs;
      run_stores(12, 1'b0, '0);
      for (int k = 0; k < 8; k++) begin
         cls = cclass_t'(rand_bits(4));
         // Even loads reuse a stored tag so that they hit
         if (k % 2 == 0)
            do_load(cls, model[cls][rand_bits(3)], 1'b0, '0);
         else
            do_load(cls, lq_dir_tag_t'(rand_bits(12)), 1'b0, '0);
      end
      end_test("store_load", e0);
   endtask

   task automatic test_store_cmp();
      int e0;
      e0 = errs;
      run_stores(16, 1'b1, '0);
      run_stores(16, 1'b1, '0);
      end_test("store_cmp", e0);
   endtask

   task automatic test_cfg_handshake();
      int e0;
      e0 = errs;
      cfg_write(`LQ_DIR_CFG_DCDIS, 1'b1);
      cfg_write(`LQ_DIR_CFG_DCDIS, 1'b0);
      cfg_write(`LQ_DIR_CFG_INJ_LD, 1'b1);
      cfg_write(`LQ_DIR_CFG_INJ_LD, 1'b0);
      cfg_write(`LQ_DIR_CFG_INJ_ST, 1'b1);
      cfg_write(`LQ_DIR_CFG_INJ_ST, 1'b0);
      end_test("cfg_handshake", e0);
   endtask

   task automatic test_parity_inject();
      int      e0;
      cclass_t cls;
      e0 = errs;
      cls = cclass_t'(rand_bits(4));
      cfg_write(`LQ_DIR_CFG_INJ_LD, 1'b1);
      do_load(cls, model[cls][0], 1'b1, '1);
      run_stores(2, 1'b1, '0);
      cfg_write(`LQ_DIR_CFG_INJ_LD, 1'b0);
      cfg_write(`LQ_DIR_CFG_INJ_ST, 1'b1);
      run_stores(2, 1'b1, '1);
      do_load(cls, model[cls][0], 1'b0, '0);
      cfg_write(`LQ_DIR_CFG_INJ_ST, 1'b0);
      do_load(cls, model[cls][1], 1'b0, '0);
      run_stores(2, 1'b1, '0);
      end_test("parity_inject", e0);
   endtask

   task automatic test_cache_disable();
      int      e0;
      cclass_t cls;
      e0 = errs;
      cls = cclass_t'(rand_bits(1));
      cfg_write(`LQ_DIR_CFG_DCDIS, 1'b1);
      cfg_write(`LQ_DIR_CFG_INJ_LD, 1'b1);
      cfg_write(`LQ_DIR_CFG_INJ_ST, 1'b1);
      // The injected parity still shows on the read data, only the errors are masked
      do_load(cls, model[cls][3], 1'b1, '0);
      run_stores(4, 1'b1, '0);
      cfg_write(`LQ_DIR_CFG_INJ_ST, 1'b0);
      cfg_write(`LQ_DIR_CFG_INJ_LD, 1'b0);
      cfg_write(`LQ_DIR_CFG_DCDIS, 1'b0);
      end_test("cache_disable", e0);
   endtask

   initial begin
      int cnt;
      cfg_wr = '0;
      ld_req = '0;
      st_req = '0;
      for (int s = 0; s < (1 << `LQ_DIR_CCLASS_W); s++) begin
         for (int w = 0; w < `LQ_DIR_WAYS; w++) begin
            model[s][w] = '0;
         end
      end
      cnt = 0;
      while (rst_n !== 1'b1 && cnt < TIMEOUT) begin
         @(posedge nclk);
         cnt++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was not released within %0d cycles", TIMEOUT);
         errs++;
      end
      test_reset_state();
      test_store_load();
      test_store_cmp();
      test_cfg_handshake();
      test_parity_inject();
      test_cache_disable();
      $display("Summary: %0d tests run, %0d errors", tests, errs);
      if (errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== lq_dir_tag.f ====
+incdir+.
lq_dir_pkg.sv
lq_dir_cfg.sv
lq_dir_tag_arr.sv
lq_dir_port_chk.sv
lq_dir_stq_pipe.sv
lq_dir_tag.sv
tb_clkgen.sv
tb_lq_dir_tag.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lq_dir_tag
FILELIST  ?= lq_dir_tag.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
